/* stq_disambig_top.f */
hw/stq_pkg.sv
hw/stq_alloc.sv
hw/stq_addr_entry.sv
hw/stq_lane_array.sv
hw/stq_disambig_top.sv
testbench/tb_stq_disambig.sv

/* Bender.yml */
package:
  name: stq_disambig

sources:
  # Package first, then the RTL leaf modules and the top level.
  - files:
      - hw/stq_pkg.sv
      - hw/stq_alloc.sv
      - hw/stq_addr_entry.sv
      - hw/stq_lane_array.sv
      - hw/stq_disambig_top.sv

  # Testbench, only for simulation targets.
  - target: test
    files:
      - testbench/tb_stq_disambig.sv

/* testbench/stq_vectors.txt */
# alloc AE AO ME MO IDX FULL | allocchk AE AO ME MO IDX M P | check PORT AE AO ME MO M P
# data IDX | state FREE UPD PASSE | commit, retire, flush, idle take no fields (PORT 2 = both)
idle
state ff 00 00
alloc 000000100 000000204 f 0 0 0
alloc 000000301 000000404 3 0 1 0
alloc 000000500 000000601 0 c 2 0
alloc 000000700 000000800 c 3 3 0
alloc 000001000 000001100 1 0 4 0
alloc 000001200 000001300 2 0 5 0
alloc 000001400 000001500 4 0 6 0
alloc 000001600 000001700 8 0 7 0
state 00 00 00
alloc 000000e00 000000f00 f 0 0 1
state 00 00 00
check 0 000000e00 000000000 f 0 00 00
check 0 000000100 000000000 3 0 01 00
check 1 000000301 000000000 f 0 00 02
check 0 000000302 000000000 3 0 00 00
check 1 000000000 000000601 0 4 04 00
check 2 000000700 000000800 c 3 08 00
check 0 000000700 000000800 c f 00 08
check 1 000000700 000000800 3 1 00 08
data 1
data 3
state 00 0a 00
commit
commit
state 00 08 03
check 0 000000100 000000000 3 0 00 00
retire
retire
retire
state 03 08 00
commit
state 03 08 04
flush
state fb 00 04
alloc 000000900 000000a00 f 0 3 0
check 2 000000900 000000000 f 0 08 00
allocchk 000000b00 000000000 f 0 4 00 00
check 0 000000b00 000000000 f 0 10 00
state e3 00 04

/* testbench/tb_stq_disambig.sv */
//////////////////////////////
// Store queue disambiguation testbench.
// Replays the vector file against the top level
// and compares indices, state and check results.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_stq_disambig import stq_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 10;
  localparam int NFIELDS = 7; // Widest vector line carries seven hex fields.
  localparam string VEC_FILE = "testbench/stq_vectors.txt";

  logic               clk;
  logic               rst;
  logic               st_en;
  logic [ADDR_W-1:0]  st_addr_even;
  logic [ADDR_W-1:0]  st_addr_odd;
  logic [MASK_W-1:0]  st_mask_even;
  logic [MASK_W-1:0]  st_mask_odd;
  logic               data_en;
  logic [IDX_W-1:0]   data_idx;
  logic               commit_en;
  logic               retire_en;
  logic               flush;
  logic               chk0_en;
  logic [ADDR_W-1:0]  chk0_addr_even;
  logic [ADDR_W-1:0]  chk0_addr_odd;
  logic [MASK_W-1:0]  chk0_mask_even;
  logic [MASK_W-1:0]  chk0_mask_odd;
  logic               chk1_en;
  logic [ADDR_W-1:0]  chk1_addr_even;
  logic [ADDR_W-1:0]  chk1_addr_odd;
  logic [MASK_W-1:0]  chk1_mask_even;
  logic [MASK_W-1:0]  chk1_mask_odd;
  logic [IDX_W-1:0]   st_idx;
  logic               full;
  logic [ENTRIES-1:0] entry_free;
  logic [ENTRIES-1:0] entry_upd;
  logic [ENTRIES-1:0] entry_passe;
  logic               chk0_valid;
  logic [ENTRIES-1:0] chk0_match;
  logic [ENTRIES-1:0] chk0_partial;
  logic               chk1_valid;
  logic [ENTRIES-1:0] chk1_match;
  logic [ENTRIES-1:0] chk1_partial;

  string       vec_op[$];
  logic [63:0] vec_f[$];  // NFIELDS values per vector, unused ones zero.
  int          errors = 0;
  int          checks = 0;
  int          cur_vec = -1;
  bit          loaded = 1'b0;

  stq_disambig_top dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at time %0t: vector %0d %s is %0h, expected %0h",
               $time, cur_vec, what, got, exp);
    end
  endtask

  task automatic clear_strobes();
    st_en <= 1'b0;
    data_en <= 1'b0;
    commit_en <= 1'b0;
    retire_en <= 1'b0;
    flush <= 1'b0;
    chk0_en <= 1'b0;
    chk1_en <= 1'b0;
  endtask

  task automatic expect_quiet();
    check_val("chk0_valid outside a check", chk0_valid, 0);
    check_val("chk1_valid outside a check", chk1_valid, 0);
  endtask

  // Port 0 or 1 selects one check port, 2 drives the same load on both.
  task automatic launch_check(input logic [63:0] port, input logic [63:0] ae,
                              input logic [63:0] ao, input logic [63:0] me,
                              input logic [63:0] mo);
    if (port != 1) begin
      chk0_en <= 1'b1;
      chk0_addr_even <= ae[ADDR_W-1:0];
      chk0_addr_odd <= ao[ADDR_W-1:0];
      chk0_mask_even <= me[MASK_W-1:0];
      chk0_mask_odd <= mo[MASK_W-1:0];
    end
    if (port != 0) begin
      chk1_en <= 1'b1;
      chk1_addr_even <= ae[ADDR_W-1:0];
      chk1_addr_odd <= ao[ADDR_W-1:0];
      chk1_mask_even <= me[MASK_W-1:0];
      chk1_mask_odd <= mo[MASK_W-1:0];
    end
  endtask

  // Called in the enable cycle. Results are due exactly two cycles later.
  task automatic finish_check(input logic [63:0] port, input logic [63:0] em,
                              input logic [63:0] ep);
    expect_quiet();
    @(posedge clk);
    clear_strobes();
    @(negedge clk);
    expect_quiet();
    @(posedge clk);
    @(negedge clk);
    check_val("chk0_valid", chk0_valid, port != 1);
    check_val("chk1_valid", chk1_valid, port != 0);
    if (port != 1) begin
      check_val("chk0_match", chk0_match, em[ENTRIES-1:0]);
      check_val("chk0_partial", chk0_partial, ep[ENTRIES-1:0]);
    end
    if (port != 0) begin
      check_val("chk1_match", chk1_match, em[ENTRIES-1:0]);
      check_val("chk1_partial", chk1_partial, ep[ENTRIES-1:0]);
    end
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    int          c;
    int          want;
    bit          done;
    string       op;
    logic [63:0] f [NFIELDS];
    ok = 1'b1;
    done = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s.", VEC_FILE);
      ok = 1'b0;
    end else begin
      while (!done && ok) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) begin
          done = 1'b1;
        end else if (op.getc(0) == "#") begin
          c = 0;
          while (c != "\n" && c != -1) c = $fgetc(fd);
        end else begin
          case (op)
            "alloc": want = 6;
            "allocchk", "check": want = 7;
            "data": want = 1;
            "state": want = 3;
            "commit", "retire", "flush", "idle": want = 0;
            default: begin
              $display("Unknown operation %s in the vector file.", op);
              ok = 1'b0;
            end
          endcase
          for (int j = 0; j < NFIELDS; j++) f[j] = '0;
          for (int j = 0; j < want && ok; j++) begin
            if ($fscanf(fd, "%h", f[j]) != 1) begin
              $display("The %s line after vector %0d has missing fields.", op, vec_op.size());
              ok = 1'b0;
            end
          end
          vec_op.push_back(op);
          for (int j = 0; j < NFIELDS; j++) vec_f.push_back(f[j]);
        end
      end
      $fclose(fd);
      if (ok && vec_op.size() == 0) begin
        $display("The vector file holds no operations.");
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_vector(input int i);
    string       op;
    logic [63:0] f [NFIELDS];
    op = vec_op[i];
    for (int j = 0; j < NFIELDS; j++) f[j] = vec_f[NFIELDS*i+j];
    cur_vec = i;
    @(posedge clk);
    clear_strobes();
    case (op)
      "alloc", "allocchk": begin
        st_en <= 1'b1;
        st_addr_even <= f[0][ADDR_W-1:0];
        st_addr_odd <= f[1][ADDR_W-1:0];
        st_mask_even <= f[2][MASK_W-1:0];
        st_mask_odd <= f[3][MASK_W-1:0];
      end
      "data": begin
        data_en <= 1'b1;
        data_idx <= f[0][IDX_W-1:0];
      end
      "commit": commit_en <= 1'b1;
      "retire": retire_en <= 1'b1;
      "flush": flush <= 1'b1;
      "check": launch_check(f[0], f[1], f[2], f[3], f[4]);
      default: ;
    endcase
    if (op == "allocchk") launch_check(2, f[0], f[1], f[2], f[3]); // Load equals the store.
    @(negedge clk);
    if (op == "alloc" || op == "allocchk") check_val("st_idx", st_idx, f[4]);
    if (op == "alloc") check_val("full", full, f[5]);
    if (op == "state") begin
      check_val("entry_free", entry_free, f[0]);
      check_val("entry_upd", entry_upd, f[1]);
      check_val("entry_passe", entry_passe, f[2]);
    end
    if (op == "check") begin
      finish_check(f[0], f[5], f[6]);
    end else if (op == "allocchk") begin
      finish_check(2, f[5], f[6]);
    end else begin
      expect_quiet();
    end
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    rst = 1'b1;
    st_addr_even = '0;
    st_addr_odd = '0;
    st_mask_even = '0;
    st_mask_odd = '0;
    data_idx = '0;
    chk0_addr_even = '0;
    chk0_addr_odd = '0;
    chk0_mask_even = '0;
    chk0_mask_odd = '0;
    chk1_addr_even = '0;
    chk1_addr_odd = '0;
    chk1_mask_even = '0;
    chk1_mask_odd = '0;
    clear_strobes();
    load_vectors(ok);
    if (!ok) begin
      $display("TB FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < vec_op.size(); i++) run_vector(i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

  // Every vector finishes well inside four clock cycles.
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(vec_op.size()) * 4 * CLK_PERIOD + 200;
    #(limit_ns);
    $display("Timeout: the vectors did not finish within %0d ns.", limit_ns);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/stq_disambig_top.sv */
//////////////////////////////
// Store queue disambiguation top level.
// Ties the allocator, the address entries and
// the byte-lane array into one queue.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stq_disambig_top import stq_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               st_en,
  input  logic [ADDR_W-1:0]  st_addr_even,
  input  logic [ADDR_W-1:0]  st_addr_odd,
  input  logic [MASK_W-1:0]  st_mask_even,
  input  logic [MASK_W-1:0]  st_mask_odd,
  input  logic               data_en,
  input  logic [IDX_W-1:0]   data_idx,
  input  logic               commit_en,
  input  logic               retire_en,
  input  logic               flush,
  input  logic               chk0_en,
  input  logic [ADDR_W-1:0]  chk0_addr_even,
  input  logic [ADDR_W-1:0]  chk0_addr_odd,
  input  logic [MASK_W-1:0]  chk0_mask_even,
  input  logic [MASK_W-1:0]  chk0_mask_odd,
  input  logic               chk1_en,
  input  logic [ADDR_W-1:0]  chk1_addr_even,
  input  logic [ADDR_W-1:0]  chk1_addr_odd,
  input  logic [MASK_W-1:0]  chk1_mask_even,
  input  logic [MASK_W-1:0]  chk1_mask_odd,
  output logic [IDX_W-1:0]   st_idx,
  output logic               full,
  output logic [ENTRIES-1:0] entry_free,
  output logic [ENTRIES-1:0] entry_upd,
  output logic [ENTRIES-1:0] entry_passe,
  output logic               chk0_valid,
  output logic [ENTRIES-1:0] chk0_match,
  output logic [ENTRIES-1:0] chk0_partial,
  output logic               chk1_valid,
  output logic [ENTRIES-1:0] chk1_match,
  output logic [ENTRIES-1:0] chk1_partial
);

  stq_addr_u st_even_u;
  stq_addr_u st_odd_u;
  stq_addr_u chk0_even_u;
  stq_addr_u chk0_odd_u;
  stq_addr_u chk1_even_u;
  stq_addr_u chk1_odd_u;

  logic [ENTRIES-1:0]   wr_onehot;
  logic [ENTRIES-1:0]   upd_onehot;
  logic [ENTRIES-1:0]   passe_onehot;
  logic [ENTRIES-1:0]   free_onehot;
  logic                 flush_go;
  logic [2*ENTRIES-1:0] chk0_hits;
  logic [2*ENTRIES-1:0] chk1_hits;

  assign st_even_u.raw = st_addr_even;
  assign st_odd_u.raw = st_addr_odd;
  assign chk0_even_u.raw = chk0_addr_even;
  assign chk0_odd_u.raw = chk0_addr_odd;
  assign chk1_even_u.raw = chk1_addr_even;
  assign chk1_odd_u.raw = chk1_addr_odd;

  stq_alloc u_alloc (
    .clk          (clk),
    .rst          (rst),
    .st_en        (st_en),
    .commit_en    (commit_en),
    .retire_en    (retire_en),
    .flush        (flush),
    .data_en      (data_en),
    .data_idx     (data_idx),
    .st_idx       (st_idx),
    .full         (full),
    .wr_onehot    (wr_onehot),
    .upd_onehot   (upd_onehot),
    .passe_onehot (passe_onehot),
    .free_onehot  (free_onehot),
    .flush_go     (flush_go)
  );

  for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
    stq_addr_entry u_entry (
      .clk            (clk),
      .rst            (rst),
      .wr_en          (wr_onehot[e]),
      .wr_addr_even   (st_even_u),
      .wr_addr_odd    (st_odd_u),
      .upd_en         (upd_onehot[e]),
      .passe_en       (passe_onehot[e]),
      .free_en        (free_onehot[e]),
      .flush_go       (flush_go),
      .chk0_addr_even (chk0_even_u),
      .chk0_addr_odd  (chk0_odd_u),
      .chk1_addr_even (chk1_even_u),
      .chk1_addr_odd  (chk1_odd_u),
      .free           (entry_free[e]),
      .upd            (entry_upd[e]),
      .passe          (entry_passe[e]),
      .chk0_hit       (chk0_hits[2*e +: 2]),
      .chk1_hit       (chk1_hits[2*e +: 2])
    );
  end

  stq_lane_array u_lanes (
    .clk            (clk),
    .rst            (rst),
    .wr_onehot      (wr_onehot),
    .wr_bank_even   (st_even_u.fields.bank),
    .wr_bank_odd    (st_odd_u.fields.bank),
    .wr_mask_even   (st_mask_even),
    .wr_mask_odd    (st_mask_odd),
    .chk0_en        (chk0_en),
    .chk1_en        (chk1_en),
    .chk0_bank_even (chk0_even_u.fields.bank),
    .chk0_bank_odd  (chk0_odd_u.fields.bank),
    .chk1_bank_even (chk1_even_u.fields.bank),
    .chk1_bank_odd  (chk1_odd_u.fields.bank),
    .chk0_mask_even (chk0_mask_even),
    .chk0_mask_odd  (chk0_mask_odd),
    .chk1_mask_even (chk1_mask_even),
    .chk1_mask_odd  (chk1_mask_odd),
    .chk0_hits      (chk0_hits),
    .chk1_hits      (chk1_hits),
    .chk0_valid     (chk0_valid),
    .chk0_match     (chk0_match),
    .chk0_partial   (chk0_partial),
    .chk1_valid     (chk1_valid),
    .chk1_match     (chk1_match),
    .chk1_partial   (chk1_partial)
  );

endmodule

`default_nettype wire

/* hw/stq_lane_array.sv */
//////////////////////////////
// Store queue byte-lane array.
// Keeps bank and byte masks per entry and resolves
// tag hits into match and partial vectors over a
// two-stage registered pipeline per check port.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stq_lane_array import stq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [ENTRIES-1:0]   wr_onehot,
  input  logic [BANK_W-1:0]    wr_bank_even,
  input  logic [BANK_W-1:0]    wr_bank_odd,
  input  logic [MASK_W-1:0]    wr_mask_even,
  input  logic [MASK_W-1:0]    wr_mask_odd,
  input  logic                 chk0_en,
  input  logic                 chk1_en,
  input  logic [BANK_W-1:0]    chk0_bank_even,
  input  logic [BANK_W-1:0]    chk0_bank_odd,
  input  logic [BANK_W-1:0]    chk1_bank_even,
  input  logic [BANK_W-1:0]    chk1_bank_odd,
  input  logic [MASK_W-1:0]    chk0_mask_even,
  input  logic [MASK_W-1:0]    chk0_mask_odd,
  input  logic [MASK_W-1:0]    chk1_mask_even,
  input  logic [MASK_W-1:0]    chk1_mask_odd,
  input  logic [2*ENTRIES-1:0] chk0_hits,
  input  logic [2*ENTRIES-1:0] chk1_hits,
  output logic                 chk0_valid,
  output logic [ENTRIES-1:0]   chk0_match,
  output logic [ENTRIES-1:0]   chk0_partial,
  output logic                 chk1_valid,
  output logic [ENTRIES-1:0]   chk1_match,
  output logic [ENTRIES-1:0]   chk1_partial
);

  // Store side lanes, one slot per queue entry.
  logic [ENTRIES-1:0][BANK_W-1:0] bank_even;
  logic [ENTRIES-1:0][BANK_W-1:0] bank_odd;
  logic [ENTRIES-1:0][MASK_W-1:0] mask_even;
  logic [ENTRIES-1:0][MASK_W-1:0] mask_odd;

  // Check ports gathered so both share one body of logic.
  logic [CHK_PORTS-1:0]                 en_in;
  logic [CHK_PORTS-1:0][2*ENTRIES-1:0]  hits_in;
  logic [CHK_PORTS-1:0][BANK_W-1:0]     bank_e_in;
  logic [CHK_PORTS-1:0][BANK_W-1:0]     bank_o_in;
  logic [CHK_PORTS-1:0][MASK_W-1:0]     mask_e_in;
  logic [CHK_PORTS-1:0][MASK_W-1:0]     mask_o_in;

  logic [CHK_PORTS-1:0]                 s1_en;
  logic [CHK_PORTS-1:0][2*ENTRIES-1:0]  s1_hits;
  logic [CHK_PORTS-1:0][BANK_W-1:0]     s1_bank_e;
  logic [CHK_PORTS-1:0][BANK_W-1:0]     s1_bank_o;
  logic [CHK_PORTS-1:0][MASK_W-1:0]     s1_mask_e;
  logic [CHK_PORTS-1:0][MASK_W-1:0]     s1_mask_o;

  logic [CHK_PORTS-1:0][ENTRIES-1:0]    match_c;
  logic [CHK_PORTS-1:0][ENTRIES-1:0]    partial_c;
  logic [CHK_PORTS-1:0]                 valid_q;
  logic [CHK_PORTS-1:0][ENTRIES-1:0]    match_q;
  logic [CHK_PORTS-1:0][ENTRIES-1:0]    partial_q;

  assign en_in = {chk1_en, chk0_en};
  assign hits_in = {chk1_hits, chk0_hits};
  assign bank_e_in = {chk1_bank_even, chk0_bank_even};
  assign bank_o_in = {chk1_bank_odd, chk0_bank_odd};
  assign mask_e_in = {chk1_mask_even, chk0_mask_even};
  assign mask_o_in = {chk1_mask_odd, chk0_mask_odd};

  always_ff @(posedge clk) begin
    for (int e = 0; e < ENTRIES; e++) begin
      if (wr_onehot[e]) begin
        bank_even[e] <= wr_bank_even;
        bank_odd[e] <= wr_bank_odd;
        mask_even[e] <= wr_mask_even;
        mask_odd[e] <= wr_mask_odd;
      end
    end
  end

  // Stage 1 captures the check as it stood in its enable cycle.
  always_ff @(posedge clk) begin
    s1_hits <= hits_in;
    s1_bank_e <= bank_e_in;
    s1_bank_o <= bank_o_in;
    s1_mask_e <= mask_e_in;
    s1_mask_o <= mask_o_in;
  end

  always_comb begin
    logic act_e, act_o;
    logic ovl_e, ovl_o;
    logic cov_e, cov_o;
    match_c = '0;
    partial_c = '0;
    for (int p = 0; p < CHK_PORTS; p++) begin
      for (int e = 0; e < ENTRIES; e++) begin
        act_e = |s1_mask_e[p];
        act_o = |s1_mask_o[p];
        ovl_e = act_e && s1_hits[p][2*e+HIT_EVEN] && (s1_bank_e[p] == bank_even[e]) &&
                |(s1_mask_e[p] & mask_even[e]);
        ovl_o = act_o && s1_hits[p][2*e+HIT_ODD] && (s1_bank_o[p] == bank_odd[e]) &&
                |(s1_mask_o[p] & mask_odd[e]);
        cov_e = ovl_e && ((s1_mask_e[p] & ~mask_even[e]) == '0);
        cov_o = ovl_o && ((s1_mask_o[p] & ~mask_odd[e]) == '0);
        match_c[p][e] = (ovl_e || ovl_o) && (!act_e || cov_e) && (!act_o || cov_o);
        partial_c[p][e] = (ovl_e || ovl_o) && !match_c[p][e];
      end
    end
  end

  // Stage 2 result registers.
  always_ff @(posedge clk) begin
    match_q <= match_c;
    partial_q <= partial_c;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_en <= '0;
      valid_q <= '0;
    end else begin
      s1_en <= en_in;
      valid_q <= s1_en;
    end
  end

  assign chk0_valid = valid_q[0];
  assign chk0_match = match_q[0];
  assign chk0_partial = partial_q[0];
  assign chk1_valid = valid_q[1];
  assign chk1_match = match_q[1];
  assign chk1_partial = partial_q[1];

endmodule

`default_nettype wire

/* hw/stq_addr_entry.sv */
//////////////////////////////
// Store queue address entry.
// Holds the even and odd line tags and the entry
// state, and compares both check ports against them.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stq_addr_entry import stq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_en,
  input  stq_addr_u wr_addr_even,
  input  stq_addr_u wr_addr_odd,
  input  logic      upd_en,
  input  logic      passe_en,
  input  logic      free_en,
  input  logic      flush_go,
  input  stq_addr_u chk0_addr_even,
  input  stq_addr_u chk0_addr_odd,
  input  stq_addr_u chk1_addr_even,
  input  stq_addr_u chk1_addr_odd,
  output logic      free,
  output logic      upd,
  output logic      passe,
  output logic [1:0] chk0_hit,
  output logic [1:0] chk1_hit
);

  logic [TAG_W-1:0] tag_even;
  logic [TAG_W-1:0] tag_odd;
  logic             live;

  // Committed stores no longer take part in disambiguation.
  assign live = !free && !passe;

  assign chk0_hit[HIT_EVEN] = live && (chk0_addr_even.fields.tag == tag_even);
  assign chk0_hit[HIT_ODD] = live && (chk0_addr_odd.fields.tag == tag_odd);
  assign chk1_hit[HIT_EVEN] = live && (chk1_addr_even.fields.tag == tag_even);
  assign chk1_hit[HIT_ODD] = live && (chk1_addr_odd.fields.tag == tag_odd);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_even <= wr_addr_even.fields.tag;
      tag_odd <= wr_addr_odd.fields.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free <= 1'b1;
      upd <= 1'b0;
      passe <= 1'b0;
    end else begin
      if (wr_en) begin
        free <= 1'b0;
        upd <= 1'b0;
        passe <= 1'b0;
      end
      if (upd_en) begin
        upd <= 1'b1;
      end
      if (passe_en) begin
        passe <= 1'b1;
        upd <= 1'b0;
      end
      if (free_en) begin // Retire of the head entry.
        free <= 1'b1;
        upd <= 1'b0;
        passe <= 1'b0;
      end
      // A commit in the flush cycle keeps its store.
      if (flush_go && !passe && !passe_en) begin
        free <= 1'b1;
        upd <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/stq_alloc.sv */
//////////////////////////////
// Store queue allocator.
// Keeps head, commit and tail pointers and turns
// allocate, commit, retire and flush into one-hot
// entry strobes and a full flag.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stq_alloc import stq_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               st_en,
  input  logic               commit_en,
  input  logic               retire_en,
  input  logic               flush,
  input  logic               data_en,
  input  logic [IDX_W-1:0]   data_idx,
  output logic [IDX_W-1:0]   st_idx,
  output logic               full,
  output logic [ENTRIES-1:0] wr_onehot,
  output logic [ENTRIES-1:0] upd_onehot,
  output logic [ENTRIES-1:0] passe_onehot,
  output logic [ENTRIES-1:0] free_onehot,
  output logic               flush_go
);

  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] cmt;
  logic [IDX_W-1:0] tail;
  logic [CNT_W-1:0] count;  // Entries holding a store.
  logic [CNT_W-1:0] ccount; // Entries committed but not yet retired.

  logic             do_alloc;
  logic             do_commit;
  logic             do_retire;
  logic [IDX_W-1:0] cmt_next;
  logic [CNT_W-1:0] ccount_next;

  function automatic logic [ENTRIES-1:0] onehot(input logic [IDX_W-1:0] idx);
    logic [ENTRIES-1:0] vec;
    vec = '0;
    vec[idx] = 1'b1;
    return vec;
  endfunction

  assign full = (count == CNT_W'(ENTRIES));
  assign st_idx = tail;

  assign do_alloc = st_en && !full && !flush; // Flush wins over a store.
  assign do_commit = commit_en && (ccount < count);
  assign do_retire = retire_en && (ccount != '0);

  assign cmt_next = cmt + IDX_W'(do_commit);
  assign ccount_next = ccount + CNT_W'(do_commit) - CNT_W'(do_retire);

  assign wr_onehot = do_alloc ? onehot(tail) : '0;
  assign upd_onehot = data_en ? onehot(data_idx) : '0;
  assign passe_onehot = do_commit ? onehot(cmt) : '0;
  assign free_onehot = do_retire ? onehot(head) : '0;
  assign flush_go = flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      cmt <= '0;
      tail <= '0;
      count <= '0;
      ccount <= '0;
    end else begin
      head <= head + IDX_W'(do_retire);
      cmt <= cmt_next;
      ccount <= ccount_next;
      if (flush) begin
        tail <= cmt_next; // Only committed stores stay in the queue.
        count <= ccount_next;
      end else begin
        tail <= tail + IDX_W'(do_alloc);
        count <= count + CNT_W'(do_alloc) - CNT_W'(do_retire);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/stq_pkg.sv */
//////////////////////////////
// Store queue disambiguation definitions.
// Queue geometry, the address decode union
// and the layout of the per-entry hit pairs.
//////////////////////////////
`default_nettype none

package stq_pkg;

  // Queue geometry.
  localparam int ENTRIES = 8;
  localparam int IDX_W = 3;
  localparam int CNT_W = IDX_W + 1; // Occupancy has to reach ENTRIES itself.

  // Number of load check ports.
  localparam int CHK_PORTS = 2;

  // Address split. The line tag sits above the bank select.
  localparam int ADDR_W = 36;
  localparam int BANK_W = 2;
  localparam int TAG_W = ADDR_W - BANK_W;

  // Byte mask width per line half.
  localparam int MASK_W = 4;

  // Bit positions inside each entry's two-bit hit pair.
  // An entry is free when it holds no store, upd once its data has
  // arrived, and passe once the store has committed. Hits are only
  // reported while the entry is live and not yet passe.
  localparam int HIT_EVEN = 0;
  localparam int HIT_ODD = 1;

  // One address word, seen either whole or as tag and bank.
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [BANK_W-1:0] bank;
    } fields;
  } stq_addr_u;

endpackage

`default_nettype wire
